/* files.f */
hdl/alu_core_pkg.sv
hdl/id_decoder.sv
hdl/ex_alu.sv
hdl/wb_regfile.sv
hdl/alu_core_top.sv
tb/alu_core_checker.sv
tb/tb_alu_core.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_alu_core -f files.f -o sim_alu_core \
  || { echo "Build failed"; exit 1; }
./obj_dir/sim_alu_core | tee /dev/stderr | grep -q "Testbench passed" \
  && echo "Simulation OK" \
  || { echo "Simulation reported failure"; exit 1; }

/* tb/tb_alu_core.sv */
// Testbench for the decode-and-execute unit
// Drives instructions over req/ack, predicts each write-back report
// with a reference model and hands it to the checker
`timescale 1ns/100ps

module tb_alu_core;

  // Reduced register file, so index range errors can be hit
  localparam int unsigned NumRegs    = 16;
  localparam int unsigned AckTimeout = 20;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    instr_req_i;
  alu_core_pkg::instr_t    instr_i;
  logic                    instr_ack_o;
  logic                    wb_valid_o;
  logic                    wb_we_o;
  alu_core_pkg::reg_addr_t wb_waddr_o;
  alu_core_pkg::data_t     wb_wdata_o;
  logic                    wb_illegal_o;

  integer              seed;
  alu_core_pkg::data_t model_q [32];
  int                  tb_errors;
  int                  tests_passed;
  int                  tests_failed;

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  alu_core_top #(
    .NumRegs (NumRegs)
  ) i_alu_core_top (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .instr_req_i  (instr_req_i),
    .instr_i      (instr_i),
    .instr_ack_o  (instr_ack_o),
    .wb_valid_o   (wb_valid_o),
    .wb_we_o      (wb_we_o),
    .wb_waddr_o   (wb_waddr_o),
    .wb_wdata_o   (wb_wdata_o),
    .wb_illegal_o (wb_illegal_o)
  );

  alu_core_checker i_alu_core_checker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wb_valid_i   (wb_valid_o),
    .wb_we_i      (wb_we_o),
    .wb_waddr_i   (wb_waddr_o),
    .wb_wdata_i   (wb_wdata_o),
    .wb_illegal_i (wb_illegal_o)
  );

  //////////////////////////////
  // Encoders and helpers
  //////////////////////////////

  function automatic alu_core_pkg::instr_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, alu_core_pkg::OPC_OP};
  endfunction

  function automatic alu_core_pkg::instr_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, alu_core_pkg::OPC_OP_IMM};
  endfunction

  function automatic alu_core_pkg::instr_t u_type(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, alu_core_pkg::OPC_LUI};
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic int total_errors();
    return tb_errors + i_alu_core_checker.error_count;
  endfunction

  function automatic logic reg_ok(input alu_core_pkg::reg_addr_t idx);
    return {27'b0, idx} < NumRegs;
  endfunction

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // RV32I integer result, alt selects SUB or SRA
  function automatic alu_core_pkg::data_t alu_model(input logic [2:0] f3, input logic alt,
      input alu_core_pkg::data_t a, input alu_core_pkg::data_t b);
    logic [4:0]          sh;
    logic [32:0]         diff;
    alu_core_pkg::data_t res;
    sh   = b[4:0];
    // Bit 32 is the unsigned borrow
    diff = {1'b0, a} - {1'b0, b};
    case (f3)
      3'd0: res = alt ? diff[31:0] : a + b;
      3'd1: res = a << sh;
      // Differing signs decide by the sign of a alone
      3'd2: res = {31'b0, (a[31] != b[31]) ? a[31] : diff[32]};
      3'd3: res = {31'b0, diff[32]};
      3'd4: res = a ^ b;
      3'd5: begin
        res = a >> sh;
        if (alt && a[31]) begin
          res = res | ~(32'hffff_ffff >> sh);
        end
      end
      3'd6: res = a | b;
      default: res = a & b;
    endcase
    return res;
  endfunction

  function automatic void ref_exec(input alu_core_pkg::instr_t instr,
      input alu_core_pkg::data_t regs [32], output logic we,
      output alu_core_pkg::reg_addr_t waddr, output alu_core_pkg::data_t wdata,
      output logic illegal);
    logic [2:0]          f3;
    logic [6:0]          f7;
    logic                alt;
    alu_core_pkg::data_t a;
    alu_core_pkg::data_t b;
    f3      = instr[14:12];
    f7      = instr[31:25];
    waddr   = instr[11:7];
    a       = regs[instr[19:15]];
    b       = regs[instr[24:20]];
    alt     = 1'b0;
    wdata   = '0;
    illegal = 1'b0;
    case (instr[6:0])
      alu_core_pkg::OPC_OP: begin
        illegal = !((f7 == alu_core_pkg::funct7_zero) ||
                    ((f7 == alu_core_pkg::funct7_sub) && ((f3 == 3'd0) || (f3 == 3'd5))));
        illegal = illegal || !reg_ok(instr[19:15]) || !reg_ok(instr[24:20]) || !reg_ok(waddr);
        alt     = f7[5];
        wdata   = alu_model(f3, alt, a, b);
      end
      alu_core_pkg::OPC_OP_IMM: begin
        b = {{20{instr[31]}}, instr[31:20]};
        if (f3 == 3'd1) begin
          illegal = (f7 != alu_core_pkg::funct7_zero);
        end else if (f3 == 3'd5) begin
          illegal = (f7 != alu_core_pkg::funct7_zero) && (f7 != alu_core_pkg::funct7_sub);
        end
        illegal = illegal || !reg_ok(instr[19:15]) || !reg_ok(waddr);
        // Only SRAI uses bit 30, elsewhere it is immediate
        alt     = (f3 == 3'd5) && instr[30];
        wdata   = alu_model(f3, alt, a, b);
      end
      alu_core_pkg::OPC_LUI: begin
        illegal = !reg_ok(waddr);
        wdata   = {instr[31:12], 12'h000};
      end
      default: illegal = 1'b1;
    endcase
    we = !illegal && (waddr != '0);
  endfunction

  //////////////////////////////
  // Handshake
  //////////////////////////////

  task automatic run_instr(input alu_core_pkg::instr_t instr);
    logic                    exp_we;
    alu_core_pkg::reg_addr_t exp_waddr;
    alu_core_pkg::data_t     exp_wdata;
    logic                    exp_illegal;
    int unsigned             gap;
    int unsigned             hold;
    int unsigned             waited;
    ref_exec(instr, model_q, exp_we, exp_waddr, exp_wdata, exp_illegal);
    i_alu_core_checker.push_expected(exp_we, exp_waddr, exp_wdata, exp_illegal);
    if (exp_we) begin
      model_q[exp_waddr] = exp_wdata;
    end
    gap  = rand_below(4);
    hold = rand_below(4);
    repeat (gap) @(negedge clk_i);
    instr_i     = instr;
    instr_req_i = 1'b1;
    // Ack expected two edges after the request
    waited = 0;
    while (!instr_ack_o && (waited < AckTimeout)) begin
      @(negedge clk_i);
      waited++;
    end
    if (!instr_ack_o) begin
      $display("No acknowledge within %0d cycles for instruction %h", AckTimeout, instr);
      tb_errors++;
    end else if (waited != 2) begin
      $display("ERROR %0t: instr_ack_o latency expected 2 actual %0d", $time, waited);
      tb_errors++;
    end
    // Ack stays up as long as the request is held
    for (int unsigned h = 0; h < hold; h++) begin
      @(negedge clk_i);
      if (instr_ack_o !== 1'b1) begin
        $display("ERROR %0t: instr_ack_o expected 1 actual %b", $time, instr_ack_o);
        tb_errors++;
      end
    end
    instr_req_i = 1'b0;
    waited = 0;
    while (instr_ack_o && (waited < AckTimeout)) begin
      @(negedge clk_i);
      waited++;
    end
    if (instr_ack_o) begin
      $display("Acknowledge still high %0d cycles after the request dropped", AckTimeout);
      tb_errors++;
    end else if (waited != 1) begin
      $display("ERROR %0t: instr_ack_o release latency expected 1 actual %0d", $time,
               waited);
      tb_errors++;
    end
  endtask

  // LUI plus ADDI, lower part is sign extended by ADDI
  task automatic load_reg(input logic [4:0] rd, input alu_core_pkg::data_t value);
    alu_core_pkg::data_t upper;
    upper = value - {{20{value[11]}}, value[11:0]};
    run_instr(u_type(upper[31:12], rd));
    run_instr(i_type(value[11:0], rd, 3'd0, rd));
  endtask

  task automatic finish_test(input string name, input int start_errors);
    if (i_alu_core_checker.pending() != 0) begin
      $display("%s: %0d expected write-back reports never arrived", name,
               i_alu_core_checker.pending());
      i_alu_core_checker.flush_expected();
      tb_errors++;
    end
    if (total_errors() == start_errors) begin
      tests_passed++;
      $display("Test %s: PASS", name);
    end else begin
      tests_failed++;
      $display("Test %s: FAIL with %0d errors", name, total_errors() - start_errors);
    end
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic check_reset_state();
    int start;
    start = total_errors();
    if (instr_ack_o !== 1'b0) begin
      $display("ERROR %0t: instr_ack_o expected 0 actual %b", $time, instr_ack_o);
      tb_errors++;
    end
    if (wb_valid_o !== 1'b0) begin
      $display("ERROR %0t: wb_valid_o expected 0 actual %b", $time, wb_valid_o);
      tb_errors++;
    end
    for (int r = 0; r < NumRegs; r++) begin
      run_instr(i_type(12'h000, 5'(r), 3'd0, 5'(r)));
    end
    finish_test("reset", start);
  endtask

  task automatic sweep_op_imm();
    alu_core_pkg::data_t vals [4] = '{32'h8000_0000, 32'h1234_5678, 32'hffff_fff0,
                                      32'h7fff_ffff};
    logic [11:0] imms [6] = '{12'h000, 12'h001, 12'hfff, 12'h7ff, 12'h800, 12'h555};
    logic [2:0]  ops [6]  = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
    logic [4:0]  shs [4]  = '{5'd0, 5'd1, 5'd15, 5'd31};
    int start;
    start = total_errors();
    for (int r = 0; r < 4; r++) begin
      load_reg(5'(r + 1), vals[r]);
    end
    for (int r = 0; r < 4; r++) begin
      for (int o = 0; o < 6; o++) begin
        for (int m = 0; m < 6; m++) begin
          run_instr(i_type(imms[m], 5'(r + 1), ops[o], 5'd5));
        end
      end
      // SLLI, SRLI, SRAI
      for (int s = 0; s < 4; s++) begin
        run_instr(i_type({alu_core_pkg::funct7_zero, shs[s]}, 5'(r + 1), 3'd1, 5'd5));
        run_instr(i_type({alu_core_pkg::funct7_zero, shs[s]}, 5'(r + 1), 3'd5, 5'd5));
        run_instr(i_type({alu_core_pkg::funct7_sub, shs[s]}, 5'(r + 1), 3'd5, 5'd5));
      end
    end
    finish_test("op_imm", start);
  endtask

  task automatic sweep_register_ops();
    alu_core_pkg::data_t vals [6] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff,
                                      32'h8000_0000, 32'h7fff_ffff, 32'h0000_0021};
    logic [6:0] f7s [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00,
                             7'h00, 7'h00, 7'h20, 7'h00, 7'h00};
    logic [2:0] f3s [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    int start;
    start = total_errors();
    for (int r = 0; r < 6; r++) begin
      load_reg(5'(r + 1), vals[r]);
    end
    for (int o = 0; o < 10; o++) begin
      for (int a = 1; a <= 6; a++) begin
        for (int b = 1; b <= 6; b++) begin
          run_instr(r_type(f7s[o], 5'(b), 5'(a), f3s[o], 5'd7));
        end
      end
    end
    finish_test("op", start);
  endtask

  task automatic exercise_lui_x0();
    int start;
    start = total_errors();
    run_instr(u_type(20'habcde, 5'd8));
    run_instr(u_type(20'hfffff, 5'd9));
    run_instr(u_type(20'h00001, 5'd10));
    // Writes to x0 are dropped
    run_instr(u_type(20'h12345, 5'd0));
    run_instr(i_type(12'h005, 5'd1, 3'd0, 5'd0));
    run_instr(r_type(7'h00, 5'd9, 5'd8, 3'd0, 5'd0));
    run_instr(i_type(12'h000, 5'd0, 3'd0, 5'd11));
    run_instr(r_type(7'h00, 5'd0, 5'd0, 3'd6, 5'd12));
    finish_test("lui_x0", start);
  endtask

  task automatic inject_illegal();
    logic [6:0] bad_opc [4] = '{7'h03, 7'h6f, 7'h00, 7'h7f};
    int start;
    start = total_errors();
    for (int i = 0; i < 4; i++) begin
      run_instr({25'h00a_08a3, bad_opc[i]});
    end
    // Bad funct7
    run_instr(r_type(7'h01, 5'd2, 5'd1, 3'd0, 5'd3));
    run_instr(r_type(7'h20, 5'd2, 5'd1, 3'd1, 5'd3));
    run_instr(r_type(7'h20, 5'd2, 5'd1, 3'd7, 5'd3));
    run_instr(r_type(7'h40, 5'd2, 5'd1, 3'd5, 5'd3));
    run_instr(i_type({7'h20, 5'd3}, 5'd1, 3'd1, 5'd3));
    run_instr(i_type({7'h01, 5'd3}, 5'd1, 3'd5, 5'd3));
    // Register indices past the file
    run_instr(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd20));
    run_instr(r_type(7'h00, 5'd31, 5'd1, 3'd0, 5'd3));
    run_instr(r_type(7'h00, 5'd2, 5'd17, 3'd0, 5'd3));
    run_instr(i_type(12'h001, 5'd16, 3'd0, 5'd3));
    run_instr(i_type(12'h001, 5'd1, 3'd0, 5'd30));
    run_instr(u_type(20'h00001, 5'd16));
    // Read back every register, contents must be unchanged
    for (int r = 1; r < NumRegs; r++) begin
      run_instr(i_type(12'h000, 5'(r), 3'd0, 5'(r)));
    end
    finish_test("illegal", start);
  endtask

  task automatic random_run();
    alu_core_pkg::instr_t instr;
    int unsigned          sel;
    int                   start;
    start = total_errors();
    for (int n = 0; n < 300; n++) begin
      instr = $random(seed);
      sel   = rand_below(8);
      if (sel < 3) begin
        instr[6:0] = alu_core_pkg::OPC_OP;
        if (rand_below(4) != 0) begin
          instr[31:25] = instr[30] ? alu_core_pkg::funct7_sub : alu_core_pkg::funct7_zero;
        end
      end else if (sel < 6) begin
        instr[6:0] = alu_core_pkg::OPC_OP_IMM;
        if (rand_below(4) != 0) begin
          instr[31] = 1'b0;
          instr[29:25] = 5'd0;
        end
      end else if (sel == 6) begin
        instr[6:0] = alu_core_pkg::OPC_LUI;
      end
      // Mostly in-range register indices
      if (rand_below(8) != 0) begin
        instr[11] = 1'b0;
        instr[19] = 1'b0;
        instr[24] = 1'b0;
      end
      run_instr(instr);
    end
    finish_test("random", start);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    seed         = 32'h52fb_a2e5;
    rst_ni       = 1'b0;
    instr_req_i  = 1'b0;
    instr_i      = '0;
    tb_errors    = 0;
    tests_passed = 0;
    tests_failed = 0;
    for (int i = 0; i < 32; i++) begin
      model_q[i] = '0;
    end
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    check_reset_state();
    sweep_op_imm();
    sweep_register_ops();
    exercise_lui_x0();
    inject_illegal();
    random_run();

    $display("%0d tests passed, %0d tests failed, %0d reports checked", tests_passed,
             tests_failed, i_alu_core_checker.checked_count);
    if ((tests_failed == 0) && (total_errors() == 0)) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* tb/alu_core_checker.sv */
// Write-back checker for the decode-and-execute unit
// Pops one expected report per wb_valid_o pulse and compares the fields
`timescale 1ns/100ps

module alu_core_checker (
  input logic                    clk_i,
  input logic                    rst_ni,
  input logic                    wb_valid_i,
  input logic                    wb_we_i,
  input alu_core_pkg::reg_addr_t wb_waddr_i,
  input alu_core_pkg::data_t     wb_wdata_i,
  input logic                    wb_illegal_i
);

  // One expected write-back report
  typedef struct packed {
    logic                    we;
    alu_core_pkg::reg_addr_t waddr;
    alu_core_pkg::data_t     wdata;
    logic                    illegal;
  } wb_report_t;

  wb_report_t exp_q [$];
  wb_report_t cur;

  int error_count   = 0;
  int checked_count = 0;

  //////////////////////////////
  // Queue access for the testbench top
  //////////////////////////////

  task automatic push_expected(input logic we, input alu_core_pkg::reg_addr_t waddr,
                               input alu_core_pkg::data_t wdata, input logic illegal);
    wb_report_t item;
    item.we      = we;
    item.waddr   = waddr;
    item.wdata   = wdata;
    item.illegal = illegal;
    exp_q.push_back(item);
  endtask

  function automatic int pending();
    return exp_q.size();
  endfunction

  task automatic flush_expected();
    exp_q.delete();
  endtask

  // One field, widened to 32 bits
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERROR %0t: %s expected %0h actual %0h", $time, name, expected, actual);
      error_count++;
    end
  endtask

  //////////////////////////////
  // Compare
  //////////////////////////////

  // Report fields change on the rising edge, sampled on the falling one
  always @(negedge clk_i) begin
    if (rst_ni && wb_valid_i) begin
      if (exp_q.size() == 0) begin
        $display("At %0t the DUT reported a write-back with no instruction outstanding",
                 $time);
        error_count++;
      end else begin
        cur = exp_q.pop_front();
        check_value("wb_illegal_o", {31'b0, cur.illegal}, {31'b0, wb_illegal_i});
        check_value("wb_we_o", {31'b0, cur.we}, {31'b0, wb_we_i});
        check_value("wb_waddr_o", {27'b0, cur.waddr}, {27'b0, wb_waddr_i});
        // Data of an illegal instruction carries no meaning
        if (!cur.illegal) begin
          check_value("wb_wdata_o", cur.wdata, wb_wdata_i);
        end
        checked_count++;
      end
    end
  end

endmodule

/* hdl/alu_core_top.sv */
// Decode-and-execute unit top level
// Four-phase req/ack front end, instruction register, decode, ALU
// and register file with a one-cycle write-back report
`timescale 1ns/100ps

module alu_core_top #(
  parameter int unsigned NumRegs = 32
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Instruction handshake
  input  logic                    instr_req_i,
  input  alu_core_pkg::instr_t    instr_i,
  output logic                    instr_ack_o,
  // Write-back report
  output logic                    wb_valid_o,
  output logic                    wb_we_o,
  output alu_core_pkg::reg_addr_t wb_waddr_o,
  output alu_core_pkg::data_t     wb_wdata_o,
  output logic                    wb_illegal_o
);

  ////////////////////////////////
  // Handshake FSM
  ////////////////////////////////

  // ACK is the report cycle, RELEASE holds ack until req drops
  typedef enum logic [1:0] {
    IDLE,
    EXEC,
    ACK,
    RELEASE
  } state_e;

  state_e state_q;
  state_e state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (instr_req_i) state_d = EXEC;
      // Single cycle, result is committed at the end of it
      EXEC:    state_d = ACK;
      ACK:     state_d = instr_req_i ? RELEASE : IDLE;
      RELEASE: if (!instr_req_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  logic commit;

  assign commit      = (state_q == EXEC);
  assign instr_ack_o = (state_q == ACK) || (state_q == RELEASE);

  // Instruction register, loaded when a request is accepted
  alu_core_pkg::instr_t instr_q;

  always_ff @(posedge clk_i) begin
    if ((state_q == IDLE) && instr_req_i) begin
      instr_q <= instr_i;
    end
  end

  ////////////////////////////////
  // Datapath
  ////////////////////////////////

  alu_core_pkg::reg_addr_t rf_raddr_a;
  alu_core_pkg::reg_addr_t rf_raddr_b;
  alu_core_pkg::data_t     rf_rdata_a;
  alu_core_pkg::data_t     rf_rdata_b;
  alu_core_pkg::alu_op_e   alu_op;
  alu_core_pkg::data_t     alu_operand_a;
  alu_core_pkg::data_t     alu_operand_b;
  alu_core_pkg::data_t     alu_result;
  alu_core_pkg::reg_addr_t rf_waddr;
  logic                    rf_we;
  logic                    illegal;

  id_decoder #(
    .NumRegs (NumRegs)
  ) i_id_decoder (
    .instr_i         (instr_q),
    .rf_raddr_a_o    (rf_raddr_a),
    .rf_raddr_b_o    (rf_raddr_b),
    .rf_rdata_a_i    (rf_rdata_a),
    .rf_rdata_b_i    (rf_rdata_b),
    .alu_op_o        (alu_op),
    .alu_operand_a_o (alu_operand_a),
    .alu_operand_b_o (alu_operand_b),
    .rf_waddr_o      (rf_waddr),
    .rf_we_o         (rf_we),
    .illegal_o       (illegal)
  );

  ex_alu i_ex_alu (
    .alu_op_i    (alu_op),
    .operand_a_i (alu_operand_a),
    .operand_b_i (alu_operand_b),
    .result_o    (alu_result)
  );

  // Writes the result and reports it in the cycle after commit
  wb_regfile #(
    .NumRegs (NumRegs)
  ) i_wb_regfile (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .raddr_a_i    (rf_raddr_a),
    .raddr_b_i    (rf_raddr_b),
    .rdata_a_o    (rf_rdata_a),
    .rdata_b_o    (rf_rdata_b),
    .commit_i     (commit),
    .we_i         (rf_we),
    .waddr_i      (rf_waddr),
    .wdata_i      (alu_result),
    .illegal_i    (illegal),
    .wb_valid_o   (wb_valid_o),
    .wb_we_o      (wb_we_o),
    .wb_waddr_o   (wb_waddr_o),
    .wb_wdata_o   (wb_wdata_o),
    .wb_illegal_o (wb_illegal_o)
  );

endmodule

/* hdl/wb_regfile.sv */
// Register file with registered write-back report
// Two combinational read ports, one write port taken on commit
`timescale 1ns/100ps

module wb_regfile #(
  parameter int unsigned NumRegs = 32
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Read ports
  input  alu_core_pkg::reg_addr_t raddr_a_i,
  input  alu_core_pkg::reg_addr_t raddr_b_i,
  output alu_core_pkg::data_t     rdata_a_o,
  output alu_core_pkg::data_t     rdata_b_o,
  // Write request
  input  logic                    commit_i,
  input  logic                    we_i,
  input  alu_core_pkg::reg_addr_t waddr_i,
  input  alu_core_pkg::data_t     wdata_i,
  input  logic                    illegal_i,
  // Write-back report
  output logic                    wb_valid_o,
  output logic                    wb_we_o,
  output alu_core_pkg::reg_addr_t wb_waddr_o,
  output alu_core_pkg::data_t     wb_wdata_o,
  output logic                    wb_illegal_o
);

  localparam int unsigned IdxW = $clog2(NumRegs);

  alu_core_pkg::data_t rf_q [NumRegs];
  logic                wr_en;

  // x0 and indices past the file read as zero
  always_comb begin
    rdata_a_o = '0;
    rdata_b_o = '0;
    if ((raddr_a_i != '0) && (raddr_a_i < NumRegs)) begin
      rdata_a_o = rf_q[raddr_a_i[IdxW-1:0]];
    end
    if ((raddr_b_i != '0) && (raddr_b_i < NumRegs)) begin
      rdata_b_o = rf_q[raddr_b_i[IdxW-1:0]];
    end
  end

  ////////////////////////////////
  // Storage
  ////////////////////////////////

  // x0 is never written, range check guards against aliasing
  assign wr_en = commit_i & we_i & (waddr_i != '0) & (waddr_i < NumRegs);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned i = 0; i < NumRegs; i++) begin
        rf_q[i] <= '0;
      end
    end else if (wr_en) begin
      rf_q[waddr_i[IdxW-1:0]] <= wdata_i;
    end
  end

  ////////////////////////////////
  // Report
  ////////////////////////////////

  // Flags pulse with valid, we shows whether the write really happened
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_valid_o   <= 1'b0;
      wb_we_o      <= 1'b0;
      wb_illegal_o <= 1'b0;
    end else begin
      wb_valid_o   <= commit_i;
      wb_we_o      <= wr_en;
      wb_illegal_o <= commit_i & illegal_i;
    end
  end

  // Address and data of the report
  always_ff @(posedge clk_i) begin
    if (commit_i) begin
      wb_waddr_o <= waddr_i;
      wb_wdata_o <= wdata_i;
    end
  end

endmodule

/* hdl/ex_alu.sv */
// Integer ALU
// Add/sub, signed and unsigned compare, logic ops, shifts and LUI pass
`timescale 1ns/100ps

module ex_alu (
  input  alu_core_pkg::alu_op_e alu_op_i,
  input  alu_core_pkg::data_t   operand_a_i,
  input  alu_core_pkg::data_t   operand_b_i,
  output alu_core_pkg::data_t   result_o
);

  ////////////////////////////////
  // Shared sub-results
  ////////////////////////////////

  // Shift amount from the low bits of B
  logic [alu_core_pkg::shamt_w-1:0] shamt;
  assign shamt = operand_b_i[alu_core_pkg::shamt_w-1:0];

  // Compare results, zero-extended to the data width
  logic lt_signed;
  logic lt_unsigned;

  assign lt_signed   = $signed(operand_a_i) < $signed(operand_b_i);
  assign lt_unsigned = operand_a_i < operand_b_i;

  // Arithmetic right shift keeps the sign of A
  alu_core_pkg::data_t sra_result;
  assign sra_result = alu_core_pkg::data_t'($signed(operand_a_i) >>> shamt);

  ////////////////////////////////
  // Result select
  ////////////////////////////////

  always_comb begin
    case (alu_op_i)
      alu_core_pkg::ALU_ADD:    result_o = operand_a_i + operand_b_i;
      // Wraps on underflow as in RV32I
      alu_core_pkg::ALU_SUB:    result_o = operand_a_i - operand_b_i;
      alu_core_pkg::ALU_SLL:    result_o = operand_a_i << shamt;
      alu_core_pkg::ALU_SLT:    result_o = {{(alu_core_pkg::xlen-1){1'b0}}, lt_signed};
      alu_core_pkg::ALU_SLTU:   result_o = {{(alu_core_pkg::xlen-1){1'b0}}, lt_unsigned};
      alu_core_pkg::ALU_XOR:    result_o = operand_a_i ^ operand_b_i;
      alu_core_pkg::ALU_SRL:    result_o = operand_a_i >> shamt;
      alu_core_pkg::ALU_SRA:    result_o = sra_result;
      alu_core_pkg::ALU_OR:     result_o = operand_a_i | operand_b_i;
      alu_core_pkg::ALU_AND:    result_o = operand_a_i & operand_b_i;
      // LUI, immediate already shifted by the decoder
      alu_core_pkg::ALU_PASS_B: result_o = operand_b_i;
      default:                  result_o = '0;
    endcase
  end

endmodule

/* hdl/id_decoder.sv */
// Instruction decoder
// Splits the instruction word, builds immediates, selects ALU operands
// and flags illegal encodings and out-of-range register indices
`timescale 1ns/100ps

module id_decoder #(
  parameter int unsigned NumRegs = 32
) (
  input  alu_core_pkg::instr_t    instr_i,
  // Register file read
  output alu_core_pkg::reg_addr_t rf_raddr_a_o,
  output alu_core_pkg::reg_addr_t rf_raddr_b_o,
  input  alu_core_pkg::data_t     rf_rdata_a_i,
  input  alu_core_pkg::data_t     rf_rdata_b_i,
  // ALU
  output alu_core_pkg::alu_op_e   alu_op_o,
  output alu_core_pkg::data_t     alu_operand_a_o,
  output alu_core_pkg::data_t     alu_operand_b_o,
  // Register file write request
  output alu_core_pkg::reg_addr_t rf_waddr_o,
  output logic                    rf_we_o,
  output logic                    illegal_o
);

  // Map funct3 to an operator, alt picks SUB / SRA
  function automatic alu_core_pkg::alu_op_e op_from_funct3(logic [2:0] f3, logic alt);
    alu_core_pkg::alu_op_e op;
    case (f3)
      3'b000:  op = alt ? alu_core_pkg::ALU_SUB : alu_core_pkg::ALU_ADD;
      3'b001:  op = alu_core_pkg::ALU_SLL;
      3'b010:  op = alu_core_pkg::ALU_SLT;
      3'b011:  op = alu_core_pkg::ALU_SLTU;
      3'b100:  op = alu_core_pkg::ALU_XOR;
      3'b101:  op = alt ? alu_core_pkg::ALU_SRA : alu_core_pkg::ALU_SRL;
      3'b110:  op = alu_core_pkg::ALU_OR;
      default: op = alu_core_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  ////////////////////////////////
  // Instruction fields
  ////////////////////////////////

  logic [6:0]              opcode;
  logic [2:0]              funct3;
  logic [6:0]              funct7;
  alu_core_pkg::reg_addr_t rs1;
  alu_core_pkg::reg_addr_t rs2;
  alu_core_pkg::reg_addr_t rd;

  assign opcode = instr_i[6:0];
  assign rd     = instr_i[11:7];
  assign funct3 = instr_i[14:12];
  assign rs1    = instr_i[19:15];
  assign rs2    = instr_i[24:20];
  assign funct7 = instr_i[31:25];

  // Sign-extended I-type and zero-filled U-type immediates
  alu_core_pkg::data_t imm_i_type;
  alu_core_pkg::data_t imm_u_type;

  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_u_type = {instr_i[31:12], 12'b0};

  ////////////////////////////////
  // Decode
  ////////////////////////////////

  logic                rs1_used;
  logic                rs2_used;
  logic                rd_used;
  logic                use_imm;
  logic                illegal_enc;
  logic                illegal_reg;
  alu_core_pkg::data_t imm_b;

  always_comb begin
    rs1_used    = 1'b0;
    rs2_used    = 1'b0;
    rd_used     = 1'b0;
    use_imm     = 1'b0;
    illegal_enc = 1'b0;
    imm_b       = imm_i_type;
    alu_op_o    = alu_core_pkg::ALU_ADD;

    case (opcode)
      alu_core_pkg::OPC_OP: begin
        rs1_used = 1'b1;
        rs2_used = 1'b1;
        rd_used  = 1'b1;
        alu_op_o = op_from_funct3(funct3, funct7 == alu_core_pkg::funct7_sub);
        // Only ADD/SUB and SRL/SRA have an alternate funct7
        if (funct7 == alu_core_pkg::funct7_sub) begin
          illegal_enc = (funct3 != 3'b000) && (funct3 != 3'b101);
        end else begin
          illegal_enc = (funct7 != alu_core_pkg::funct7_zero);
        end
      end
      alu_core_pkg::OPC_OP_IMM: begin
        rs1_used = 1'b1;
        rd_used  = 1'b1;
        use_imm  = 1'b1;
        // Bit 30 is part of the immediate except for the right shifts
        alu_op_o = op_from_funct3(funct3, (funct3 == 3'b101) && instr_i[30]);
        if (funct3 == 3'b001) begin
          illegal_enc = (funct7 != alu_core_pkg::funct7_zero);
        end else if (funct3 == 3'b101) begin
          illegal_enc = (funct7 != alu_core_pkg::funct7_zero) &&
                        (funct7 != alu_core_pkg::funct7_sub);
        end
      end
      alu_core_pkg::OPC_LUI: begin
        rd_used  = 1'b1;
        use_imm  = 1'b1;
        imm_b    = imm_u_type;
        alu_op_o = alu_core_pkg::ALU_PASS_B;
      end
      default: begin
        illegal_enc = 1'b1;
      end
    endcase
  end

  // Any used index beyond the implemented register count is illegal
  assign illegal_reg = (rs1_used && (rs1 >= NumRegs)) ||
                       (rs2_used && (rs2 >= NumRegs)) ||
                       (rd_used  && (rd  >= NumRegs));

  assign illegal_o = illegal_enc | illegal_reg;

  ////////////////////////////////
  // Operands and register ports
  ////////////////////////////////

  // Unused source fields read x0 so immediates never index the file
  assign rf_raddr_a_o = rs1_used ? rs1 : '0;
  assign rf_raddr_b_o = rs2_used ? rs2 : '0;

  assign alu_operand_a_o = rf_rdata_a_i;
  assign alu_operand_b_o = use_imm ? imm_b : rf_rdata_b_i;

  assign rf_waddr_o = rd;
  // No write request for an illegal instruction
  assign rf_we_o    = rd_used & ~illegal_o;

endmodule

/* hdl/alu_core_pkg.sv */
// Shared definitions for the integer decode-and-execute unit
// Widths, word types, RV32I opcode and funct7 encodings, ALU operators
package alu_core_pkg;

  ////////////////////////////////
  // Widths
  ////////////////////////////////

  // Data path width
  localparam int unsigned xlen       = 32;
  // Register index width, covers the full 32-entry space
  localparam int unsigned reg_addr_w = 5;
  // Shift amount taken from the low bits of operand B
  localparam int unsigned shamt_w    = 5;

  ////////////////////////////////
  // Word types
  ////////////////////////////////

  typedef logic [31:0]           instr_t;
  typedef logic [xlen-1:0]       data_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  ////////////////////////////////
  // Encodings
  ////////////////////////////////

  // Major opcodes of the supported instruction classes
  typedef enum logic [6:0] {
    OPC_OP     = 7'h33,
    OPC_OP_IMM = 7'h13,
    OPC_LUI    = 7'h37
  } opcode_e;

  // ALU operators
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10   // LUI result is the U-type immediate
  } alu_op_e;

  // funct7 of SUB and SRA/SRAI
  localparam logic [6:0] funct7_sub  = 7'b010_0000;
  // funct7 of the remaining R-type ops and of SLLI/SRLI
  localparam logic [6:0] funct7_zero = 7'b000_0000;

endpackage
